// ==== Bender.yml ====
package:
  name: s1c88_core

sources:
  - include_dirs:
      - include
    files:
      - design/s1c88_pkg.sv
      - design/cycle_control.sv
      - design/fetch_unit.sv
      - design/micro_sequencer.sv
      - design/bus_driver.sv
      - design/s1c88_core.sv
  - target: simulation
    files:
      - sim/clk_gen.sv
      - sim/tb_s1c88_core.sv

// ==== design/bus_driver.sv ====
`timescale 1ns/1ps

module bus_driver
    import s1c88_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  bus_phase_t  phase,
    input  bus_req_t    bus_req,
    output logic [23:0] address_out,
    output logic [7:0]  data_out,
    output bus_status_e bus_status,
    output logic        read,
    output logic        write,
    output logic        sync,
    output logic        iack,
    output logic        pk,
    output logic        pl
);
    logic        active;
    logic        wr_kind;
    logic        rd_kind;
    bus_status_e status_next;

    assign active = (bus_req.kind != KIND_NONE);
    assign wr_kind = (bus_req.kind == KIND_DATA_WRITE);
    // the acknowledge dummy is a read as well
    assign rd_kind = active && !wr_kind;

    always_comb
    begin
        case (bus_req.kind)
            KIND_NONE:       status_next = BUS_IDLE;
            KIND_IACK_DUMMY: status_next = BUS_IRQ_READ;
            KIND_DATA_WRITE: status_next = BUS_MEM_WRITE;
            default:         status_next = BUS_MEM_READ;
        endcase
    end

    // pins follow the phase counter one clk later
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            address_out <= '1;
            data_out <= '1;
            bus_status <= BUS_IDLE;
            pk <= 1'b0;
            pl <= 1'b0;
            read <= 1'b0;
            write <= 1'b0;
            sync <= 1'b0;
            iack <= 1'b0;
        end
        else
        begin
            if (phase == 2'd0)
            begin
                address_out <= bus_req.address;
                bus_status <= status_next;
                if (wr_kind)
                    data_out <= bus_req.wdata;
            end
            pk <= active && (phase == 2'd1 || phase == 2'd2);
            pl <= active && (phase == 2'd2 || phase == 2'd3);
            read <= rd_kind && (phase == 2'd1 || phase == 2'd2);
            // write sits where pk and pl overlap
            write <= wr_kind && (phase == 2'd2);
            sync <= (bus_req.kind == KIND_OPCODE_FETCH);
            iack <= (bus_req.kind == KIND_IACK_DUMMY);
        end
    end

    a_no_read_write: assert property (@(posedge clk) disable iff (reset)
        !(read && write));

endmodule

// ==== design/cycle_control.sv ====
`timescale 1ns/1ps

module cycle_control
    import s1c88_pkg::*;
#(
    parameter int RESET_HOLD_CYCLES = 2
)
(
    input  logic         clk,
    input  logic         reset,
    input  logic [15:0]  pc,
    input  logic [1:0]   imm_count,
    input  logic         step_done,
    input  data_req_t    data_req,
    output cycle_state_e state,
    output bus_phase_t   phase,
    output bus_req_t     bus_req
);
    localparam int HOLD_W = (RESET_HOLD_CYCLES > 1) ? $clog2(RESET_HOLD_CYCLES) : 1;
    localparam logic [HOLD_W-1:0] HOLD_LAST = HOLD_W'(RESET_HOLD_CYCLES - 1);

    logic [HOLD_W-1:0] hold_count;
    logic [1:0]        exc_step;
    logic [1:0]        next_exc_step;
    cycle_state_e      next_state;
    cycle_state_e      after_operands;
    bus_req_t          next_req;

    // once the operand bytes are in, the micro word picks fetch or a bus step
    assign after_operands = step_done ? CYC_FETCH : CYC_EXECUTE;

    always_comb
    begin
        next_state = state;
        next_exc_step = exc_step;
        case (state)
            CYC_EXC_PROCESS:
            begin
                next_exc_step = exc_step + 2'd1;
                if (exc_step == 2'd2)
                    next_state = CYC_FETCH;
            end
            CYC_FETCH:
                next_state = (imm_count == 2'd0) ? after_operands : CYC_IMM_LOW_READ;
            CYC_IMM_LOW_READ:
                next_state = (imm_count == 2'd2) ? CYC_IMM_HIGH_READ : after_operands;
            CYC_IMM_HIGH_READ, CYC_EXECUTE:
                next_state = after_operands;
            default:
                next_state = state;
        endcase
    end

    // fetch and operand reads only see the low 15 bits of pc
    always_comb
    begin
        next_req.kind = KIND_NONE;
        next_req.address = {9'd0, pc[14:0]};
        next_req.wdata = data_req.wdata;
        case (next_state)
            CYC_EXC_PROCESS:
            begin
                next_req.kind = (next_exc_step == 2'd1) ? KIND_VECTOR_LOW : KIND_VECTOR_HIGH;
                next_req.address = (next_exc_step == 2'd1) ? VECTOR_ADDR_LOW : VECTOR_ADDR_HIGH;
            end
            CYC_FETCH:
                next_req.kind = KIND_OPCODE_FETCH;
            CYC_IMM_LOW_READ, CYC_IMM_HIGH_READ:
                next_req.kind = KIND_IMM_READ;
            CYC_EXECUTE:
            begin
                if (data_req.valid)
                    next_req.kind = (data_req.dir == DIR_WRITE) ? KIND_DATA_WRITE : KIND_DATA_READ;
                next_req.address = {8'h00, data_req.br, data_req.ll};
            end
            default:
                next_req.kind = KIND_NONE;
        endcase
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            state <= CYC_RESET_HOLD;
            phase <= '0;
            hold_count <= '0;
            exc_step <= '0;
            bus_req <= '{kind: KIND_NONE, address: '1, wdata: '1};
        end
        else if (state == CYC_RESET_HOLD)
        begin
            if (hold_count == HOLD_LAST)
            begin
                // the reset exception opens with the acknowledge dummy
                state <= CYC_EXC_PROCESS;
                exc_step <= '0;
                bus_req <= '{kind: KIND_IACK_DUMMY, address: DUMMY_ADDR, wdata: '1};
            end
            else
            begin
                hold_count <= hold_count + 1'b1;
            end
        end
        else
        begin
            phase <= phase + 2'd1;
            if (phase == 2'd3)
            begin
                state <= next_state;
                exc_step <= next_exc_step;
                bus_req <= next_req;
            end
        end
    end

    a_req_stable: assert property (@(posedge clk) disable iff (reset)
        (state != CYC_RESET_HOLD && phase != 2'd0) |-> $stable(bus_req));

    a_hold_length: assert property (@(posedge clk) disable iff (reset)
        (state == CYC_RESET_HOLD && hold_count != HOLD_LAST) |=> state == CYC_RESET_HOLD);

endmodule

// ==== design/fetch_unit.sv ====
`timescale 1ns/1ps

module fetch_unit
    import s1c88_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic [7:0]  data_in,
    input  bus_phase_t  phase,
    input  bus_req_t    bus_req,
    output logic [15:0] pc,
    output logic [7:0]  opcode,
    output logic [7:0]  imm_low,
    output logic [7:0]  imm_high
);
    logic sample;
    // set once the first operand byte of an instruction is in
    logic imm_high_next;

    assign sample = (phase == 2'd2);

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            pc <= '0;
            opcode <= '0;
            imm_high_next <= 1'b0;
        end
        else if (sample)
        begin
            case (bus_req.kind)
                KIND_VECTOR_LOW:
                    pc[7:0] <= data_in;
                KIND_VECTOR_HIGH:
                    pc[15:8] <= data_in;
                KIND_OPCODE_FETCH:
                begin
                    opcode <= data_in;
                    pc <= pc + 16'd1;
                    imm_high_next <= 1'b0;
                end
                KIND_IMM_READ:
                begin
                    pc <= pc + 16'd1;
                    imm_high_next <= 1'b1;
                end
                default:
                begin
                end
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (sample && bus_req.kind == KIND_IMM_READ)
        begin
            if (imm_high_next)
                imm_high <= data_in;
            else
                imm_low <= data_in;
        end
    end

endmodule

// ==== design/micro_sequencer.sv ====
`timescale 1ns/1ps

module micro_sequencer
    import s1c88_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  cycle_state_e state,
    input  bus_phase_t   phase,
    input  logic [7:0]   opcode,
    input  logic [7:0]   imm_low,
    input  logic [7:0]   imm_high,
    input  logic [7:0]   data_in,
    output logic [1:0]   imm_count,
    output logic         step_done,
    output data_req_t    data_req
);
    `include "s1c88_microcode.svh"

    logic [2:0] upc;
    logic [2:0] op_addr;
    micro_op_t  cur_op;
    logic [7:0] br;
    logic [7:0] a;
    logic [7:0] src_byte;
    logic       decide;
    micro_mov_e load_dst;
    logic [7:0] load_val;

    always_comb
    begin
        case (opcode)
            OPC_MOV_BR_IMM, OPC_MOV_A_BRLL:
                imm_count = 2'd1;
            OPC_MOV_BRLL_IMM:
                imm_count = 2'd2;
            default:
                imm_count = 2'd0;
        endcase
    end

    // during a fetch the fresh opcode already points at its first word
    assign op_addr = (state == CYC_FETCH) ? micro_entry(opcode) : upc;
    assign cur_op = micro_rom(op_addr);
    assign step_done = cur_op.done;

    always_comb
    begin
        case (cur_op.src)
            MOV_IMM_LOW:  src_byte = imm_low;
            MOV_IMM_HIGH: src_byte = imm_high;
            MOV_A:        src_byte = a;
            MOV_BR:       src_byte = br;
            default:      src_byte = 8'h00;
        endcase
    end

    always_comb
    begin
        data_req.valid = (cur_op.op_type == MICRO_BUS);
        data_req.dir = cur_op.dir;
        data_req.br = br;
        data_req.ll = imm_low;
        data_req.wdata = src_byte;
    end

    // cycles whose end hands control to the micro word
    always_comb
    begin
        case (state)
            CYC_FETCH:                      decide = (imm_count == 2'd0);
            CYC_IMM_LOW_READ:               decide = (imm_count == 2'd1);
            CYC_IMM_HIGH_READ, CYC_EXECUTE: decide = 1'b1;
            default:                        decide = 1'b0;
        endcase
    end

    always_comb
    begin
        load_dst = MOV_NONE;
        load_val = src_byte;
        if (state == CYC_EXECUTE && phase == 2'd2 && cur_op.op_type == MICRO_BUS
            && cur_op.dir == DIR_READ)
        begin
            load_dst = cur_op.dst;
            load_val = data_in;
        end
        else if (decide && phase == 2'd3 && cur_op.op_type == MICRO_MISC)
        begin
            load_dst = cur_op.dst;
        end
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            upc <= '0;
            br <= '0;
            a <= '0;
        end
        else
        begin
            if (state == CYC_FETCH && phase == 2'd3)
                upc <= op_addr;
            else if (state == CYC_EXECUTE && phase == 2'd2)
                upc <= upc + 3'd1;

            case (load_dst)
                MOV_A:   a <= load_val;
                MOV_BR:  br <= load_val;
                default:
                begin
                end
            endcase
        end
    end

    // cycle_control must never schedule a bus cycle for a done word
    a_no_step_past_done: assert property (@(posedge clk) disable iff (reset)
        (state == CYC_EXECUTE && phase == 2'd2) |-> !cur_op.done);

endmodule

// ==== design/s1c88_core.sv ====
`timescale 1ns/1ps

module s1c88_core
    import s1c88_pkg::*;
#(
    parameter int RESET_HOLD_CYCLES = 2
)
(
    input  logic        clk,
    input  logic        reset,
    input  logic [7:0]  data_in,
    output logic [7:0]  data_out,
    output logic [23:0] address_out,
    output bus_status_e bus_status,
    output logic        read,
    output logic        write,
    output logic        sync,
    output logic        iack,
    output logic        pk,
    output logic        pl
);
    cycle_state_e state;
    bus_phase_t   phase;
    bus_req_t     bus_req;
    data_req_t    data_req;
    logic [15:0]  pc;
    logic [7:0]   opcode;
    logic [7:0]   imm_low;
    logic [7:0]   imm_high;
    logic [1:0]   imm_count;
    logic         step_done;

    cycle_control #(
        .RESET_HOLD_CYCLES(RESET_HOLD_CYCLES)
    ) u_cycle_control (
        .clk, .reset, .pc, .imm_count, .step_done, .data_req,
        .state, .phase, .bus_req
    );

    fetch_unit u_fetch_unit (
        .clk, .reset, .data_in, .phase, .bus_req,
        .pc, .opcode, .imm_low, .imm_high
    );

    micro_sequencer u_micro_sequencer (
        .clk, .reset, .state, .phase, .opcode, .imm_low, .imm_high, .data_in,
        .imm_count, .step_done, .data_req
    );

    bus_driver u_bus_driver (
        .clk, .reset, .phase, .bus_req,
        .address_out, .data_out, .bus_status,
        .read, .write, .sync, .iack, .pk, .pl
    );

endmodule

// ==== design/s1c88_pkg.sv ====
package s1c88_pkg;

    // command shown on bus_status
    typedef enum logic [1:0]
    {
        BUS_IDLE      = 2'd0,
        BUS_IRQ_READ  = 2'd1,
        BUS_MEM_WRITE = 2'd2,
        BUS_MEM_READ  = 2'd3
    } bus_status_e;

    typedef enum logic [2:0]
    {
        CYC_RESET_HOLD,
        CYC_EXC_PROCESS,
        CYC_FETCH,
        CYC_IMM_LOW_READ,
        CYC_IMM_HIGH_READ,
        CYC_EXECUTE
    } cycle_state_e;

    // clk position inside one bus cycle
    typedef logic [1:0] bus_phase_t;

    typedef enum logic [2:0]
    {
        KIND_NONE,
        KIND_IACK_DUMMY,
        KIND_VECTOR_LOW,
        KIND_VECTOR_HIGH,
        KIND_OPCODE_FETCH,
        KIND_IMM_READ,
        KIND_DATA_READ,
        KIND_DATA_WRITE
    } bus_kind_e;

    typedef struct packed
    {
        bus_kind_e   kind;
        logic [23:0] address;
        logic [7:0]  wdata;
    } bus_req_t;

    typedef enum logic {MICRO_MISC, MICRO_BUS} micro_type_e;

    typedef enum logic {DIR_READ, DIR_WRITE} micro_dir_e;

    typedef enum logic [2:0]
    {
        MOV_NONE,
        MOV_IMM_LOW,
        MOV_IMM_HIGH,
        MOV_A,
        MOV_BR
    } micro_mov_e;

    // all data accesses of the subset go to BR:ll
    typedef struct packed
    {
        micro_type_e op_type;
        micro_dir_e  dir;
        micro_mov_e  dst;
        micro_mov_e  src;
        logic        done;
    } micro_op_t;

    typedef struct packed
    {
        logic        valid;
        micro_dir_e  dir;
        logic [7:0]  br;
        logic [7:0]  ll;
        logic [7:0]  wdata;
    } data_req_t;

    localparam logic [7:0] OPC_MOV_BR_IMM   = 8'hB4;
    localparam logic [7:0] OPC_MOV_A_BRLL   = 8'h44;
    localparam logic [7:0] OPC_MOV_BRLL_IMM = 8'hDD;

    localparam logic [23:0] DUMMY_ADDR       = 24'hDEFACE;
    localparam logic [23:0] VECTOR_ADDR_LOW  = 24'h000000;
    localparam logic [23:0] VECTOR_ADDR_HIGH = 24'h000001;

endpackage

// ==== include/s1c88_microcode.svh ====
`ifndef S1C88_MICROCODE_SVH
`define S1C88_MICROCODE_SVH

// translation rom, opcode to first micro word
// anything not listed lands on entry 0
function automatic logic [2:0] micro_entry(input logic [7:0] op);
    case (op)
        OPC_MOV_A_BRLL:   micro_entry = 3'd1;
        OPC_MOV_BR_IMM:   micro_entry = 3'd3;
        OPC_MOV_BRLL_IMM: micro_entry = 3'd4;
        default:          micro_entry = 3'd0;
    endcase
endfunction

// micro rom, a step that is not done is always a bus step
function automatic micro_op_t micro_rom(input logic [2:0] addr);
    micro_op_t word;
    word = '{op_type: MICRO_MISC, dir: DIR_READ, dst: MOV_NONE, src: MOV_NONE, done: 1'b1};
    case (addr)
        // MOV A,[BR:ll]
        3'd1: word = '{op_type: MICRO_BUS, dir: DIR_READ, dst: MOV_A, src: MOV_NONE,
                       done: 1'b0};
        // MOV BR,#nn
        3'd3: word = '{op_type: MICRO_MISC, dir: DIR_READ, dst: MOV_BR, src: MOV_IMM_LOW,
                       done: 1'b1};
        // MOV [BR:ll],#nn
        3'd4: word = '{op_type: MICRO_BUS, dir: DIR_WRITE, dst: MOV_NONE, src: MOV_IMM_HIGH,
                       done: 1'b0};
        default: word = word;
    endcase
    return word;
endfunction

`endif

// ==== s1c88_core.f ====
+incdir+include
design/s1c88_pkg.sv
design/cycle_control.sv
design/fetch_unit.sv
design/micro_sequencer.sv
design/bus_driver.sv
design/s1c88_core.sv
sim/clk_gen.sv
sim/tb_s1c88_core.sv

// ==== sim/clk_gen.sv ====
`timescale 1ns/1ps

module clk_gen
#(
    parameter int HALF_PERIOD_NS = 20,
    parameter int RESET_CYCLES = 10
)
(
    output logic clk,
    output logic reset
);
    initial
    begin
        clk = 1'b0;
        forever #(HALF_PERIOD_NS) clk = ~clk;
    end

    // release lands just after a rising edge
    initial
    begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #5 reset = 1'b0;
    end

endmodule

// ==== sim/tb_s1c88_core.sv ====
`timescale 1ns/1ps

module tb_s1c88_core
    import s1c88_pkg::*;
();
    localparam int TIMEOUT_CYCLES = 200;
    localparam logic [15:0] RESET_PC = 16'h8140;
    localparam int MAX_ROWS = 16;

    typedef enum logic [1:0] {TXN_IACK, TXN_READ, TXN_FETCH, TXN_WRITE} txn_kind_e;

    typedef struct packed
    {
        txn_kind_e   kind;
        logic [23:0] addr;
        logic [7:0]  data;
    } txn_t;

    // one instruction with the bus cycles it must produce
    typedef struct packed
    {
        logic [7:0] opcode;
        logic [7:0] op1;
        logic [7:0] op2;
        logic [2:0] test_id;
        logic [2:0] count;
        txn_t [3:0] txn;
    } row_t;

    typedef struct packed
    {
        txn_t        txn;
        bus_status_e status;
        logic        sync;
        logic        iack;
        logic        early_write;
        logic        strobe_ok;
    } cycle_t;

    logic        clk;
    logic        reset;
    logic [7:0]  data_in;
    logic [7:0]  data_out;
    logic [23:0] address_out;
    bus_status_e bus_status;
    logic        read;
    logic        write;
    logic        sync;
    logic        iack;
    logic        pk;
    logic        pl;

    logic [7:0]  mem [0:65535];
    // what the program should leave in memory
    logic [7:0]  exp_mem [0:65535];
    row_t        rows [MAX_ROWS];
    int          num_rows;
    integer      seed;
    logic [15:0] model_pc;
    logic [7:0]  model_br;
    logic [7:0]  last_ll;
    int          test_errors [1:6];
    logic        pk_prev;
    logic        timed_out;

    clk_gen #(.HALF_PERIOD_NS(20), .RESET_CYCLES(10)) u_clk_gen (.clk, .reset);

    s1c88_core #(.RESET_HOLD_CYCLES(2)) u_dut (
        .clk, .reset, .data_in, .data_out, .address_out, .bus_status,
        .read, .write, .sync, .iack, .pk, .pl
    );

    // memory answers from whatever address is on the pins
    always @(posedge clk)
    begin
        #5;
        data_in = mem[address_out[15:0]];
    end

    function automatic logic [7:0] fill_byte(input logic [15:0] addr);
        return addr[15:8] ^ addr[7:0] ^ 8'h5A;
    endfunction

    function automatic txn_t make_txn(input txn_kind_e kind, input logic [23:0] addr,
                                      input logic [7:0] data);
        txn_t t;
        t.kind = kind;
        t.addr = addr;
        t.data = data;
        return t;
    endfunction

    function automatic string test_name(input int id);
        case (id)
            1:       return "reset values";
            2:       return "exception sequence";
            3:       return "unknown opcode";
            4:       return "mov br then write";
            5:       return "data read";
            default: return "whole program";
        endcase
    endfunction

    task automatic expect_true(input int test_id, input logic ok, input string msg);
        assert (ok)
        else
        begin
            $display("FAIL at %0d ns: test %0d, %s", $time, test_id, msg);
            test_errors[test_id]++;
        end
    endtask

    task automatic load_image();
        for (int i = 0; i < 65536; i++)
        begin
            mem[i] = fill_byte(16'(i));
            exp_mem[i] = mem[i];
        end
        // reset vector with the low byte first
        mem[0] = RESET_PC[7:0];
        mem[1] = RESET_PC[15:8];
        exp_mem[0] = RESET_PC[7:0];
        exp_mem[1] = RESET_PC[15:8];
        model_pc = RESET_PC;
        model_br = 8'h00;
        last_ll = 8'h00;
    endtask

    // program bytes sit where the 15-bit fetch address points
    task automatic place_byte(input txn_kind_e kind, input logic [7:0] value, output txn_t t);
        t = make_txn(kind, {9'd0, model_pc[14:0]}, value);
        mem[{1'b0, model_pc[14:0]}] = value;
        exp_mem[{1'b0, model_pc[14:0]}] = value;
        model_pc = model_pc + 16'd1;
    endtask

    task automatic add_row(input logic [7:0] opcode, input int test_id, input logic reuse_ll);
        row_t        row;
        logic [23:0] data_addr;
        row = '0;
        row.opcode = opcode;
        row.test_id = test_id[2:0];
        row.op1 = reuse_ll ? last_ll : 8'($random(seed));
        row.op2 = 8'($random(seed));
        // BR stays in 0x80..0xBF away from the vectors and the program
        if (opcode == OPC_MOV_BR_IMM)
            row.op1 = {2'b10, row.op1[5:0]};
        place_byte(TXN_FETCH, opcode, row.txn[0]);
        row.count = 3'd1;
        case (opcode)
            OPC_MOV_BR_IMM:
            begin
                place_byte(TXN_READ, row.op1, row.txn[1]);
                model_br = row.op1;
                row.count = 3'd2;
            end
            OPC_MOV_A_BRLL:
            begin
                place_byte(TXN_READ, row.op1, row.txn[1]);
                data_addr = {8'h00, model_br, row.op1};
                row.txn[2] = make_txn(TXN_READ, data_addr, exp_mem[data_addr[15:0]]);
                row.count = 3'd3;
            end
            OPC_MOV_BRLL_IMM:
            begin
                place_byte(TXN_READ, row.op1, row.txn[1]);
                place_byte(TXN_READ, row.op2, row.txn[2]);
                data_addr = {8'h00, model_br, row.op1};
                row.txn[3] = make_txn(TXN_WRITE, data_addr, row.op2);
                exp_mem[data_addr[15:0]] = row.op2;
                row.count = 3'd4;
            end
            default:
            begin
            end
        endcase
        last_ll = row.op1;
        rows[num_rows] = row;
        num_rows++;
    endtask

    task automatic check_reset();
        int waited;
        waited = 0;
        while (reset && waited < TIMEOUT_CYCLES)
        begin
            @(negedge clk);
            if (reset)
            begin
                expect_true(1, address_out == 24'hFFFFFF, "address_out not all ones in reset");
                expect_true(1, data_out == 8'hFF, "data_out not all ones in reset");
                expect_true(1, bus_status == BUS_IDLE, "bus_status not idle in reset");
                expect_true(1, {pk, pl, read, write, sync, iack} == 6'b0,
                            "a strobe is high in reset");
            end
            waited++;
        end
        if (reset)
        begin
            $display("timeout: reset was never released");
            timed_out = 1'b1;
            test_errors[1]++;
        end
    endtask

    // waits for the next rising pk and records that bus cycle
    task automatic capture_cycle(output cycle_t cyc);
        int   waited;
        logic started;
        cyc = '0;
        waited = 0;
        started = 1'b0;
        while (!started && !timed_out)
        begin
            @(negedge clk);
            started = pk && !pk_prev;
            pk_prev = pk;
            waited++;
            if (!started && waited >= TIMEOUT_CYCLES)
            begin
                $display("timeout: no bus cycle started within %0d clock cycles, time %0t",
                         TIMEOUT_CYCLES, $time);
                timed_out = 1'b1;
            end
        end
        if (started)
        begin
            // pk high and pl low here and the dut takes data_in at the end of this clk
            cyc.txn.addr = address_out;
            cyc.txn.data = data_in;
            cyc.status = bus_status;
            cyc.sync = sync;
            cyc.iack = iack;
            cyc.early_write = write;
            @(negedge clk);
            // pk and pl overlap here
            if (write)
            begin
                cyc.txn.kind = TXN_WRITE;
                cyc.txn.data = data_out;
                mem[address_out[15:0]] = data_out;
            end
            else if (cyc.iack)
                cyc.txn.kind = TXN_IACK;
            else if (cyc.sync)
                cyc.txn.kind = TXN_FETCH;
            else
                cyc.txn.kind = TXN_READ;
            cyc.strobe_ok = write ? (pk && pl && !read) : (read && pk);
            pk_prev = pk;
        end
    endtask

    task automatic compare_cycle(input int test_id, input txn_t exp, input cycle_t cyc);
        bus_status_e exp_status;
        exp_status = BUS_MEM_READ;
        if (exp.kind == TXN_IACK)
            exp_status = BUS_IRQ_READ;
        else if (exp.kind == TXN_WRITE)
            exp_status = BUS_MEM_WRITE;
        expect_true(test_id, cyc.txn.kind == exp.kind,
                    $sformatf("cycle kind %0d, expected %0d", cyc.txn.kind, exp.kind));
        expect_true(test_id, cyc.txn.addr == exp.addr,
                    $sformatf("address %h, expected %h", cyc.txn.addr, exp.addr));
        if (exp.kind != TXN_IACK)
            expect_true(test_id, cyc.txn.data == exp.data,
                        $sformatf("data %h at %h, expected %h", cyc.txn.data, exp.addr, exp.data));
        expect_true(test_id, cyc.status == exp_status,
                    $sformatf("bus_status %0d, expected %0d", cyc.status, exp_status));
        expect_true(test_id, cyc.sync == (exp.kind == TXN_FETCH), "sync level wrong");
        expect_true(test_id, cyc.iack == (exp.kind == TXN_IACK), "iack level wrong");
        expect_true(test_id, cyc.strobe_ok, "read or write strobe outside pk high");
        expect_true(test_id, !cyc.early_write, "write high before pl");
    endtask

    task automatic report_test(input int test_id);
        if (test_errors[test_id] == 0)
            $display("test %0d %s: ok", test_id, test_name(test_id));
        else
            $display("test %0d %s: %0d errors", test_id, test_name(test_id),
                     test_errors[test_id]);
    endtask

    initial
    begin
        txn_t   exc_txn [3];
        cycle_t cyc;
        int     failed_tests;
        int     total_errors;
        data_in = 8'h00;
        seed = 32'h4379cd7f;
        timed_out = 1'b0;
        pk_prev = 1'b0;
        num_rows = 0;
        for (int i = 1; i <= 6; i++)
            test_errors[i] = 0;

        load_image();
        add_row(8'h00, 3, 1'b0);
        add_row(8'h9A, 3, 1'b0);
        add_row(OPC_MOV_BR_IMM, 4, 1'b0);
        add_row(OPC_MOV_BRLL_IMM, 4, 1'b0);
        // first read goes back to the byte just written
        add_row(OPC_MOV_A_BRLL, 5, 1'b1);
        add_row(OPC_MOV_A_BRLL, 5, 1'b0);
        add_row(OPC_MOV_BR_IMM, 6, 1'b0);
        add_row(OPC_MOV_BRLL_IMM, 6, 1'b0);
        add_row(OPC_MOV_A_BRLL, 6, 1'b1);
        add_row(8'h3C, 6, 1'b0);

        check_reset();
        report_test(1);

        exc_txn[0] = make_txn(TXN_IACK, DUMMY_ADDR, 8'h00);
        exc_txn[1] = make_txn(TXN_READ, VECTOR_ADDR_LOW, RESET_PC[7:0]);
        exc_txn[2] = make_txn(TXN_READ, VECTOR_ADDR_HIGH, RESET_PC[15:8]);
        for (int t = 0; t < 3; t++)
        begin
            capture_cycle(cyc);
            if (timed_out)
                test_errors[2]++;
            else
                compare_cycle(2, exc_txn[t], cyc);
        end
        report_test(2);

        for (int r = 0; r < num_rows; r++)
        begin
            for (int t = 0; t < rows[r].count; t++)
            begin
                capture_cycle(cyc);
                if (timed_out)
                    test_errors[rows[r].test_id]++;
                else
                    compare_cycle(rows[r].test_id, rows[r].txn[t], cyc);
            end
            if (r == num_rows - 1 || rows[r + 1].test_id != rows[r].test_id)
                report_test(rows[r].test_id);
        end

        failed_tests = 0;
        total_errors = 0;
        for (int i = 1; i <= 6; i++)
        begin
            total_errors += test_errors[i];
            if (test_errors[i] != 0)
                failed_tests++;
        end
        $display("tests: 6, passed: %0d, failed: %0d, errors: %0d",
                 6 - failed_tests, failed_tests, total_errors);
        if (failed_tests == 0 && !timed_out)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule
